// ==== build.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/mem_op_decode.sv
hw/ahb_mem_ctrl.sv
hw/spm.sv
hw/load_align.sv
hw/lsu_top.sv
sim/ahb_slave_model.sv
sim/tb_lsu.sv

// ==== hw/ahb_mem_ctrl.sv ====
`include "lsu_consts.svh"

module ahb_mem_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            rd_en,
    input  logic                            we_en,
    input  logic                            fwd_en,
    input  logic [`LSU_WORD_WIDTH-1:0]      addr,
    input  logic [`LSU_WORD_WIDTH-1:0]      wdata,
    input  logic [3:0]                      byteena,
    input  logic [`LSU_WORD_WIDTH-1:0]      hrdata,
    input  logic                            hready,
    output logic [`LSU_WORD_WIDTH-1:0]      haddr,
    output logic [`LSU_WORD_WIDTH-1:0]      hwdata,
    output logic                            hwrite,
    output logic [2:0]                      hsize,
    output logic [2:0]                      hburst,
    output logic [1:0]                      htrans,
    output logic                            spm_rden,
    output logic                            spm_wren,
    output logic [`LSU_SPM_DEPTH_LOG2-1:0]  spm_addr,
    output logic [3:0]                      spm_byteena,
    output logic [`LSU_WORD_WIDTH-1:0]      spm_wdata,
    output logic                            stall,
    output logic                            accept,
    output logic                            bus_done,
    output logic [`LSU_WORD_WIDTH-1:0]      bus_rdata,
    output lsu_pkg::load_src_e              load_src
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_XFER = 1'b1
    } xfer_state_e;

    xfer_state_e                state;
    xfer_state_e                state_nxt;
    logic                       spm_sel;
    logic                       trans_start;
    logic [`LSU_WORD_WIDTH-1:0] hwdata_q;

    assign spm_sel = addr[`LSU_SPM_REGION] == `LSU_SPM_BASE_HI;

    // wait state in the data phase holds the CPU
    assign stall    = (state == ST_XFER) && !hready;
    assign accept   = !stall;
    assign bus_done = (state == ST_XFER) && hready;

    // forwarded loads never reach the bus
    assign trans_start = accept && !spm_sel && (we_en || (rd_en && !fwd_en));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (trans_start) begin
                    state_nxt = ST_XFER;
                end
            end
            ST_XFER: begin
                // back-to-back transfer keeps the machine busy
                if (hready && !trans_start) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // address phase
    assign htrans = trans_start ? `HTRANS_NONSEQ : `HTRANS_IDLE;
    assign haddr  = trans_start ? addr : '0;
    assign hwrite = trans_start && we_en;
    assign hburst = `HBURST_SINGLE;

    always_comb begin
        case (byteena)
            4'b1111:          hsize = `HSIZE_32;
            4'b0011, 4'b1100: hsize = `HSIZE_16;
            default:          hsize = `HSIZE_8;
        endcase
    end

    // store data frozen while the slave waits
    always_ff @(posedge clk) begin
        if (!stall) begin
            hwdata_q <= wdata;
        end
    end

    assign hwdata    = (state == ST_XFER) ? hwdata_q : '0;
    assign bus_rdata = bus_done ? hrdata : '0;

    // scratchpad port
    assign spm_rden    = accept && spm_sel && rd_en && !fwd_en;
    assign spm_wren    = accept && spm_sel && we_en;
    assign spm_addr    = addr[`LSU_SPM_DEPTH_LOG2+1:2];
    assign spm_byteena = byteena;
    assign spm_wdata   = wdata;

    assign load_src = fwd_en  ? lsu_pkg::SRC_FWD :
                      spm_sel ? lsu_pkg::SRC_SPM : lsu_pkg::SRC_AHB;

    a_no_start_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        !(htrans == `HTRANS_NONSEQ && stall));
    a_spm_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(spm_rden && spm_wren));

endmodule

// ==== hw/load_align.sv ====
`include "lsu_consts.svh"

module load_align (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        accept,
    input  lsu_pkg::mem_op_e            load_op,
    input  logic [1:0]                  byte_off,
    input  lsu_pkg::load_src_e          load_src,
    input  logic [`LSU_WORD_WIDTH-1:0]  fwd_data,
    input  logic [`LSU_WORD_WIDTH-1:0]  spm_rdata,
    input  logic [`LSU_WORD_WIDTH-1:0]  bus_rdata,
    input  logic                        bus_done,
    output logic                        load_valid,
    output logic [`LSU_WORD_WIDTH-1:0]  load_data
);

    logic                       s1_valid;
    lsu_pkg::mem_op_e           s1_op;
    logic [1:0]                 s1_off;
    lsu_pkg::load_src_e         s1_src;
    logic [`LSU_WORD_WIDTH-1:0] s1_fwd;
    logic                       s1_ahb;
    logic                       s1_local;
    logic                       s2_valid;
    lsu_pkg::mem_op_e           s2_op;
    logic [1:0]                 s2_off;
    lsu_pkg::mem_op_e           sel_op;
    logic [1:0]                 sel_off;
    logic [`LSU_WORD_WIDTH-1:0] sel_word;
    logic [`LSU_WORD_WIDTH-1:0] shifted;

    assign s1_ahb   = s1_valid && (s1_src == lsu_pkg::SRC_AHB);
    assign s1_local = s1_valid && (s1_src != lsu_pkg::SRC_AHB);

    // decode reports MEM_NONE for anything that is not a good load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept && (load_op != lsu_pkg::MEM_NONE);
            if (s1_ahb && !bus_done) begin
                s2_valid <= 1'b1;
            end else if (bus_done) begin
                s2_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && load_op != lsu_pkg::MEM_NONE) begin
            s1_op  <= load_op;
            s1_off <= byte_off;
            s1_src <= load_src;
            s1_fwd <= fwd_data;
        end
        // bus load still waiting on its data phase
        if (s1_ahb) begin
            s2_op  <= s1_op;
            s2_off <= s1_off;
        end
    end

    always_comb begin
        sel_op   = s1_op;
        sel_off  = s1_off;
        sel_word = (s1_src == lsu_pkg::SRC_FWD) ? s1_fwd : spm_rdata;
        if (!s1_local) begin
            if (!s1_ahb) begin
                sel_op  = s2_op;
                sel_off = s2_off;
            end
            sel_word = bus_rdata;
        end
        shifted = sel_word >> {sel_off, 3'b000};
        case (sel_op)
            lsu_pkg::MEM_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::MEM_LBU: load_data = {24'd0, shifted[7:0]};
            lsu_pkg::MEM_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::MEM_LHU: load_data = {16'd0, shifted[15:0]};
            default:          load_data = sel_word;
        endcase
    end

    // bus_done of a store has no pending load behind it
    assign load_valid = s1_local || (bus_done && (s1_ahb || s2_valid));

endmodule

// ==== hw/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_WORD_WIDTH      32

// top address nibble that selects the scratchpad
`define LSU_SPM_REGION      31:28
`define LSU_SPM_BASE_HI     4'h1

// scratchpad word address width, 1024 words
`define LSU_SPM_DEPTH_LOG2  10

// AHB-Lite encodings
`define HTRANS_IDLE         2'b00
`define HTRANS_NONSEQ       2'b10
`define HSIZE_8             3'b000
`define HSIZE_16            3'b001
`define HSIZE_32            3'b010
`define HBURST_SINGLE       3'b000

`endif

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

    // memory operation from the CPU
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // where a pending load takes its word from
    typedef enum logic [1:0] {
        SRC_SPM = 2'd0,
        SRC_AHB = 2'd1,
        SRC_FWD = 2'd2
    } load_src_e;

endpackage

// ==== hw/lsu_top.sv ====
`include "lsu_consts.svh"

module lsu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lsu_pkg::mem_op_e            op,
    input  logic [`LSU_WORD_WIDTH-1:0]  addr,
    input  logic [`LSU_WORD_WIDTH-1:0]  store_data,
    output logic                        stall,
    output logic                        load_valid,
    output logic [`LSU_WORD_WIDTH-1:0]  load_data,
    output logic                        misalign,
    output logic [`LSU_WORD_WIDTH-1:0]  haddr,
    output logic [1:0]                  htrans,
    output logic                        hwrite,
    output logic [2:0]                  hsize,
    output logic [2:0]                  hburst,
    output logic [`LSU_WORD_WIDTH-1:0]  hwdata,
    input  logic [`LSU_WORD_WIDTH-1:0]  hrdata,
    input  logic                        hready
);

    logic                           rd_en;
    logic                           we_en;
    logic                           fwd_en;
    logic                           accept;
    logic                           bus_done;
    logic [3:0]                     byteena;
    logic [`LSU_WORD_WIDTH-1:0]     wdata;
    logic [`LSU_WORD_WIDTH-1:0]     fwd_data;
    logic [`LSU_WORD_WIDTH-1:0]     bus_rdata;
    logic [1:0]                     byte_off;
    lsu_pkg::mem_op_e               load_op;
    lsu_pkg::load_src_e             load_src;
    logic                           spm_rden;
    logic                           spm_wren;
    logic [`LSU_SPM_DEPTH_LOG2-1:0] spm_addr;
    logic [3:0]                     spm_byteena;
    logic [`LSU_WORD_WIDTH-1:0]     spm_wdata;
    logic [`LSU_WORD_WIDTH-1:0]     spm_rdata;

    mem_op_decode u_decode (
        .clk, .rst_n, .op, .addr, .store_data, .accept,
        .rd_en, .we_en, .fwd_en, .misalign, .byteena, .wdata,
        .fwd_data, .load_op, .byte_off
    );

    ahb_mem_ctrl u_ctrl (
        .clk, .rst_n, .rd_en, .we_en, .fwd_en, .addr, .wdata, .byteena,
        .hrdata, .hready, .haddr, .hwdata, .hwrite, .hsize, .hburst, .htrans,
        .spm_rden, .spm_wren, .spm_addr, .spm_byteena, .spm_wdata,
        .stall, .accept, .bus_done, .bus_rdata, .load_src
    );

    spm u_spm (
        .clk, .rden(spm_rden), .wren(spm_wren), .addr(spm_addr),
        .byteena(spm_byteena), .wdata(spm_wdata), .rdata(spm_rdata)
    );

    load_align u_align (
        .clk, .rst_n, .accept, .load_op, .byte_off, .load_src, .fwd_data,
        .spm_rdata, .bus_rdata, .bus_done, .load_valid, .load_data
    );

endmodule

// ==== hw/mem_op_decode.sv ====
`include "lsu_consts.svh"

module mem_op_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  lsu_pkg::mem_op_e            op,
    input  logic [`LSU_WORD_WIDTH-1:0]  addr,
    input  logic [`LSU_WORD_WIDTH-1:0]  store_data,
    input  logic                        accept,
    output logic                        rd_en,
    output logic                        we_en,
    output logic                        fwd_en,
    output logic                        misalign,
    output logic [3:0]                  byteena,
    output logic [`LSU_WORD_WIDTH-1:0]  wdata,
    output logic [`LSU_WORD_WIDTH-1:0]  fwd_data,
    output lsu_pkg::mem_op_e            load_op,
    output logic [1:0]                  byte_off
);

    logic                       is_load;
    logic                       is_store;
    logic                       bad_align;
    logic                       st_valid;
    logic [`LSU_WORD_WIDTH-3:0] st_word;
    logic [`LSU_WORD_WIDTH-1:0] st_data;

    // lane enables and store data replication
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        bad_align = 1'b0;
        byteena   = 4'b0000;
        wdata     = store_data;
        case (op)
            lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU: begin
                is_load = 1'b1;
                byteena = 4'b0001 << addr[1:0];
            end
            lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU: begin
                is_load   = 1'b1;
                bad_align = addr[0];
                byteena   = 4'b0011 << addr[1:0];
            end
            lsu_pkg::MEM_LW: begin
                is_load   = 1'b1;
                bad_align = |addr[1:0];
                byteena   = 4'b1111;
            end
            lsu_pkg::MEM_SB: begin
                is_store = 1'b1;
                byteena  = 4'b0001 << addr[1:0];
                wdata    = {4{store_data[7:0]}};
            end
            lsu_pkg::MEM_SH: begin
                is_store  = 1'b1;
                bad_align = addr[0];
                byteena   = 4'b0011 << addr[1:0];
                wdata     = {2{store_data[15:0]}};
            end
            lsu_pkg::MEM_SW: begin
                is_store  = 1'b1;
                bad_align = |addr[1:0];
                byteena   = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    // a misaligned request touches no memory and yields no result
    assign rd_en    = is_load && !bad_align;
    assign we_en    = is_store && !bad_align;
    assign misalign = bad_align && accept;
    assign load_op  = rd_en ? op : lsu_pkg::MEM_NONE;
    assign byte_off = addr[1:0];

    // forward only right behind a word store to the same word
    assign fwd_en   = rd_en && st_valid && (st_word == addr[`LSU_WORD_WIDTH-1:2]);
    assign fwd_data = st_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
        end else if (accept && op != lsu_pkg::MEM_NONE) begin
            st_valid <= we_en && (op == lsu_pkg::MEM_SW);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && we_en) begin
            st_word <= addr[`LSU_WORD_WIDTH-1:2];
            st_data <= store_data;
        end
    end

    a_rd_we_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && we_en));

endmodule

// ==== hw/spm.sv ====
`include "lsu_consts.svh"

module spm (
    input  logic                            clk,
    input  logic                            rden,
    input  logic                            wren,
    input  logic [`LSU_SPM_DEPTH_LOG2-1:0]  addr,
    input  logic [3:0]                      byteena,
    input  logic [`LSU_WORD_WIDTH-1:0]      wdata,
    output logic [`LSU_WORD_WIDTH-1:0]      rdata
);

    localparam int DEPTH = 1 << `LSU_SPM_DEPTH_LOG2;

    logic [`LSU_WORD_WIDTH-1:0] mem [DEPTH];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (wren) begin
            for (int i = 0; i < 4; i++) begin
                if (byteena[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // one-cycle registered read
    always_ff @(posedge clk) begin
        if (rden) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== sim/ahb_slave_model.sv ====
`include "lsu_consts.svh"

module ahb_slave_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [2:0]  hsize,
    input  logic [31:0] hwdata,
    input  logic [1:0]  wait_cycles,
    output logic [31:0] hrdata,
    output logic        hready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [1024];
    logic        dp_active;
    logic        dp_write;
    logic [31:0] dp_addr;
    logic [2:0]  dp_size;
    logic [1:0]  wait_cnt;

    // ready whenever no data phase is open
    assign hready = !dp_active || (wait_cnt == 2'd0);
    assign hrdata = (dp_active && !dp_write) ? mem[dp_addr[11:2]] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_active <= 1'b0;
            dp_write  <= 1'b0;
            dp_addr   <= '0;
            dp_size   <= '0;
            wait_cnt  <= '0;
        end else if (hready) begin
            // address phase sampled only while ready
            dp_active <= (htrans == `HTRANS_NONSEQ);
            dp_write  <= hwrite;
            dp_addr   <= haddr;
            dp_size   <= hsize;
            wait_cnt  <= wait_cycles;
        end else begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    // write data taken in the last cycle of the data phase
    always_ff @(posedge clk) begin
        if (dp_active && dp_write && hready) begin
            case (dp_size)
                `HSIZE_8:  mem[dp_addr[11:2]][dp_addr[1:0]*8 +: 8] <= hwdata[dp_addr[1:0]*8 +: 8];
                `HSIZE_16: mem[dp_addr[11:2]][dp_addr[1]*16 +: 16] <= hwdata[dp_addr[1]*16 +: 16];
                default:   mem[dp_addr[11:2]] <= hwdata;
            endcase
        end
    end

endmodule

// ==== sim/tb_lsu.sv ====
`include "lsu_consts.svh"

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEQ_REQS  = 16;
    localparam int POOL_REQS = 16;
    localparam int RAND_REQS = 300;
    localparam int NUM_REQ   = 2 * SEQ_REQS + POOL_REQS + RAND_REQS + 8 + 12;

    logic               clk;
    logic               rst_n;
    lsu_pkg::mem_op_e   op;
    logic [31:0]        addr;
    logic [31:0]        store_data;
    logic               stall;
    logic               load_valid;
    logic [31:0]        load_data;
    logic               misalign;
    logic [31:0]        haddr;
    logic [1:0]         htrans;
    logic               hwrite;
    logic [2:0]         hsize;
    logic [2:0]         hburst;
    logic [31:0]        hwdata;
    logic [31:0]        hrdata;
    logic               hready;
    logic [1:0]         slave_wait;

    logic [31:0]        spm_shadow [1024];
    logic [31:0]        ahb_shadow [1024];
    logic               last_sw_valid;
    logic [29:0]        last_sw_word;
    logic [31:0]        exp_q [$];
    string              name_q [$];
    string              test_name;
    logic [31:0]        exp_word;
    string              exp_name;
    logic               local_due;
    logic               in_dphase;
    int                 checked;
    int                 data_errs;
    int                 other_errs;
    int unsigned        seed_val;

    lsu_top DUT (
        .clk, .rst_n, .op, .addr, .store_data, .stall, .load_valid, .load_data,
        .misalign, .haddr, .htrans, .hwrite, .hsize, .hburst, .hwdata, .hrdata, .hready
    );

    ahb_slave_model u_slave (
        .clk, .rst_n, .haddr, .htrans, .hwrite, .hsize, .hwdata,
        .wait_cycles(slave_wait), .hrdata, .hready
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // shadow memories follow the stores and each good load queues its result
    function automatic void predict_request(input lsu_pkg::mem_op_e o, input logic [31:0] a,
                                            input logic [31:0] d, output logic bad,
                                            output logic fwd, output logic is_load);
        logic [31:0] word;
        logic [31:0] sh;
        logic [31:0] res;
        logic [9:0]  idx;
        logic        in_spm;
        idx     = a[11:2];
        in_spm  = a[`LSU_SPM_REGION] == `LSU_SPM_BASE_HI;
        is_load = o inside {lsu_pkg::MEM_LB, lsu_pkg::MEM_LH, lsu_pkg::MEM_LW,
                            lsu_pkg::MEM_LBU, lsu_pkg::MEM_LHU};
        case (o)
            lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: bad = a[0];
            lsu_pkg::MEM_LW, lsu_pkg::MEM_SW:                   bad = |a[1:0];
            default:                                            bad = 1'b0;
        endcase
        fwd  = is_load && !bad && last_sw_valid && (last_sw_word == a[31:2]);
        word = in_spm ? spm_shadow[idx] : ahb_shadow[idx];
        if (!bad) begin
            case (o)
                lsu_pkg::MEM_SB: word[a[1:0]*8 +: 8] = d[7:0];
                lsu_pkg::MEM_SH: word[a[1]*16 +: 16] = d[15:0];
                lsu_pkg::MEM_SW: word = d;
                default: begin
                end
            endcase
            if (in_spm) begin
                spm_shadow[idx] = word;
            end else begin
                ahb_shadow[idx] = word;
            end
            if (is_load) begin
                sh = word >> (a[1:0] * 8);
                case (o)
                    lsu_pkg::MEM_LB:  res = {{24{sh[7]}}, sh[7:0]};
                    lsu_pkg::MEM_LBU: res = {24'd0, sh[7:0]};
                    lsu_pkg::MEM_LH:  res = {{16{sh[15]}}, sh[15:0]};
                    lsu_pkg::MEM_LHU: res = {16'd0, sh[15:0]};
                    default:          res = word;
                endcase
                exp_q.push_back(res);
                name_q.push_back(test_name);
            end
        end
        last_sw_valid = (o == lsu_pkg::MEM_SW) && !bad;
        last_sw_word  = a[31:2];
    endfunction

    // AHB transfer size of an operation
    function automatic logic [2:0] access_size(input lsu_pkg::mem_op_e o);
        case (o)
            lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU, lsu_pkg::MEM_SB: return `HSIZE_8;
            lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: return `HSIZE_16;
            default:                                            return `HSIZE_32;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
        slave_wait = 2'($urandom_range(3, 0));
    endtask

    // present one request and hold it until accepted
    task automatic issue(input lsu_pkg::mem_op_e o, input logic [31:0] a, input logic [31:0] d);
        logic       bad;
        logic       fwd;
        logic       is_load;
        logic       in_spm;
        logic       exp_nonseq;
        logic [1:0] exp_htrans;
        logic [6:0] exp_ctrl;
        op         = o;
        addr       = a;
        store_data = d;
        #1;
        while (stall) begin
            next_cycle();
            #1;
        end
        in_spm = a[`LSU_SPM_REGION] == `LSU_SPM_BASE_HI;
        predict_request(o, a, d, bad, fwd, is_load);
        exp_nonseq = !bad && !in_spm && !fwd;
        exp_htrans = exp_nonseq ? `HTRANS_NONSEQ : `HTRANS_IDLE;
        exp_ctrl   = {!is_load, access_size(o), `HBURST_SINGLE};
        if (misalign !== bad) begin
            other_errs++;
            $display("ERR %s: misalign expected %b, actual %b", test_name, bad, misalign);
        end
        if (htrans !== exp_htrans) begin
            other_errs++;
            $display("ERR %s: htrans expected %b, actual %b", test_name, exp_htrans, htrans);
        end
        if (exp_nonseq) begin
            if (haddr !== a) begin
                other_errs++;
                $display("ERR %s: haddr expected %08h, actual %08h", test_name, a, haddr);
            end
            if ({hwrite, hsize, hburst} !== exp_ctrl) begin
                other_errs++;
                $display("ERR %s: hwrite, hsize, hburst expected %b, actual %b", test_name,
                         exp_ctrl, {hwrite, hsize, hburst});
            end
        end
        next_cycle();
        local_due = is_load && !bad && (in_spm || fwd);
        op = lsu_pkg::MEM_NONE;
    endtask

    task automatic mixed_size_sequence(input logic [31:0] base);
        issue(lsu_pkg::MEM_SW,  base,     32'h80f1_7e02);
        issue(lsu_pkg::MEM_SW,  base + 4, 32'h1234_5678);
        issue(lsu_pkg::MEM_LW,  base,     '0);
        issue(lsu_pkg::MEM_LB,  base + 1, '0);
        issue(lsu_pkg::MEM_LB,  base + 3, '0);
        issue(lsu_pkg::MEM_LBU, base + 3, '0);
        issue(lsu_pkg::MEM_LH,  base + 2, '0);
        issue(lsu_pkg::MEM_LHU, base + 2, '0);
        issue(lsu_pkg::MEM_SH,  base + 6, 32'h0000_beef);
        issue(lsu_pkg::MEM_SB,  base + 5, 32'h0000_009c);
        issue(lsu_pkg::MEM_LH,  base + 6, '0);
        issue(lsu_pkg::MEM_LHU, base + 4, '0);
        issue(lsu_pkg::MEM_LB,  base + 5, '0);
        issue(lsu_pkg::MEM_LBU, base + 5, '0);
        issue(lsu_pkg::MEM_LW,  base + 4, '0);
        issue(lsu_pkg::MEM_LB,  base,     '0);
    endtask

    task automatic random_mix(input int n);
        lsu_pkg::mem_op_e o;
        logic [31:0]      a;
        for (int i = 0; i < n; i++) begin
            o = lsu_pkg::mem_op_e'(4'($urandom_range(8, 1)));
            a = ($urandom_range(1, 0) ? 32'h1000_0200 : 32'h0000_0200) + 4 * $urandom_range(7, 0);
            // offsets stay aligned to the access size
            case (o)
                lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU, lsu_pkg::MEM_SB: a = a + $urandom_range(3, 0);
                lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: a = a + 2 * $urandom_range(1, 0);
                default: begin
                end
            endcase
            issue(o, a, $urandom());
        end
    endtask

    task automatic misaligned_requests(input logic [31:0] base);
        issue(lsu_pkg::MEM_SW,  base,     32'h5a5a_c3c3);
        issue(lsu_pkg::MEM_SH,  base + 1, 32'h0000_ffff);
        issue(lsu_pkg::MEM_SW,  base + 2, 32'h0000_0000);
        issue(lsu_pkg::MEM_LH,  base + 3, '0);
        issue(lsu_pkg::MEM_LW,  base + 1, '0);
        issue(lsu_pkg::MEM_LW,  base,     '0);
    endtask

    // data phase tracking for the stall check
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_dphase <= 1'b0;
        end else if (hready) begin
            in_dphase <= (htrans == `HTRANS_NONSEQ);
        end
    end

    // results and stall checked at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (stall !== (in_dphase && !hready)) begin
                other_errs++;
                $display("ERR %s: stall expected %b, actual %b", test_name,
                         in_dphase && !hready, stall);
            end
            if (local_due && load_valid !== 1'b1) begin
                other_errs++;
                $display("load_valid missing one cycle after a local load");
            end
            local_due = 1'b0;
            if (load_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("load_valid raised with no load pending");
                end else begin
                    exp_word = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    checked++;
                    if (load_data !== exp_word) begin
                        data_errs++;
                        $display("ERR %s: expected %08h, actual %08h", exp_name, exp_word, load_data);
                    end
                end
            end
        end
    end

    initial begin
        #(NUM_REQ * (4 + 2) * 40 + 8 * 40 + 4000);
        $display("watchdog timeout, the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed_val      = $urandom(32'hed4f);
        rst_n         = 1'b0;
        op            = lsu_pkg::MEM_NONE;
        addr          = '0;
        store_data    = '0;
        slave_wait    = 2'd0;
        last_sw_valid = 1'b0;
        last_sw_word  = '0;
        local_due     = 1'b0;
        checked       = 0;
        data_errs     = 0;
        other_errs    = 0;
        test_name     = "reset";
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        test_name = "spm_sequence";
        mixed_size_sequence(32'h1000_0100);
        test_name = "ahb_sequence";
        mixed_size_sequence(32'h2000_0100);

        test_name = "random_mix";
        for (int j = 0; j < POOL_REQS / 2; j++) begin
            issue(lsu_pkg::MEM_SW, 32'h1000_0200 + 4 * j, $urandom());
            issue(lsu_pkg::MEM_SW, 32'h0000_0200 + 4 * j, $urandom());
        end
        random_mix(RAND_REQS);

        test_name = "store_forward";
        issue(lsu_pkg::MEM_SW,  32'h0000_0300, 32'hcafe_f00d);
        issue(lsu_pkg::MEM_LW,  32'h0000_0300, '0);
        issue(lsu_pkg::MEM_SW,  32'h0000_0304, 32'h8bad_f00d);
        issue(lsu_pkg::MEM_LB,  32'h0000_0307, '0);
        issue(lsu_pkg::MEM_SW,  32'h1000_0300, 32'h0123_fedc);
        issue(lsu_pkg::MEM_LHU, 32'h1000_0302, '0);
        // different word so the bus is read
        issue(lsu_pkg::MEM_SW,  32'h0000_0308, 32'h7777_1111);
        issue(lsu_pkg::MEM_LW,  32'h0000_0300, '0);

        test_name = "misaligned";
        misaligned_requests(32'h0000_0400);
        misaligned_requests(32'h1000_0400);

        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();

        $display("loads checked %0d, data errors %0d, other errors %0d",
                 checked, data_errs, other_errs);
        if (data_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
